// File: Makefile
.PHONY: sim clean

# builds the testbench with timing support and runs it from the project root,
# so the simulator's exit status reports pass or fail.
sim:
	verilator --binary --timing --assert --top-module jamSolverTb \
		-f compile.f -o jamSolverSim
	./obj_dir/jamSolverSim

clean:
	rm -rf obj_dir

// File: compile.f
source/permPkg.sv
source/costPkg.sv
source/permutationStepper.sv
source/costAccumulator.sv
source/minCostTracker.sv
source/jamSolver.sv
sim/jamSolverTb.sv

// File: sim/costPatterns.dat
// each table is eight rows of costs, row = worker 0..7 and column = job 0..7.
// after each table comes the expected minimum total and the count of permutations reaching it.
10 12 14 16 18 1A 1C 1E
11 13 15 17 19 1B 1D 1F
12 14 16 18 1A 1C 1E 20
13 15 17 19 1B 1D 1F 21
14 16 18 1A 1C 1E 20 22
15 17 19 1B 1D 1F 21 23
16 18 1A 1C 1E 20 22 24
17 19 1B 1D 1F 21 23 25
D4 9D80
40 41 42 01 44 45 46 47
41 42 43 44 02 46 47 48
42 43 44 45 46 03 48 49
43 44 45 46 47 48 04 4A
44 45 46 47 48 49 4A 05
06 46 47 48 49 4A 4B 4C
46 07 48 49 4A 4B 4C 4D
47 48 08 4A 4B 4C 4D 4E
24 0001
02 02 02 02 64 65 66 67
03 03 03 03 64 65 66 67
04 04 04 04 64 65 66 67
05 05 05 05 64 65 66 67
60 61 62 63 06 06 06 06
60 61 62 63 07 07 07 07
60 61 62 63 08 08 08 08
60 61 62 63 09 09 09 09
2C 0240

// File: sim/jamSolverTb.sv
`timescale 1ns/1ns

module jamSolverTb;
    import permPkg::*;
    import costPkg::*;

    localparam int tableCount = 3;
    localparam int tableWords = workerCount * workerCount + 2;  // 64 costs, minimum, count.
    localparam int resetCycles = 10;
    localparam int settleCycles = 32;

    // every permutation costs at most 27 cycles, plus reset and settling per table.
    localparam int cycleLimit = tableCount * (permTotal * 27 + resetCycles + settleCycles + 8);

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic [costWidth-1:0]  cost;
    logic [indexWidth-1:0] worker;
    logic [indexWidth-1:0] job;
    logic [sumWidth-1:0]   minCost;
    logic [countWidth-1:0] matchCount;
    logic                  done;

    logic [15:0] patterns [tableCount * tableWords];
    int tableSel = 0;
    int cycles = 0;

    logic [indexWidth-1:0] passJobs [workerCount];
    logic [indexWidth-1:0] prevWorker;
    logic [indexWidth-1:0] prevJob;
    int passPos;
    int passCount;
    int prevValue;
    int tallyMin;
    int tallyCount;

    jamSolver dut0 (
        .clk        (clk),
        .rst        (rst),
        .cost       (cost),
        .worker     (worker),
        .job        (job),
        .minCost    (minCost),
        .matchCount (matchCount),
        .done       (done)
    );

    always #50 clk = ~clk;

    // the cost memory answers in the same cycle.
    assign cost = costWidth'(patterns[tableSel * tableWords
                                      + int'(worker) * workerCount + int'(job)]);

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run aborted");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("FAILED table %0d %s: expected 0x%0h, actual 0x%0h",
                               tableSel, testName, expected, actual));
        end
    endtask

    // jobs read as a base-8 number with worker 7 as the top digit.
    function automatic int encodeOrder(input bit identity);
        int value;
        value = 0;
        for (int w = workerCount - 1; w >= 0; w--) begin
            value = value * workerCount + (identity ? w : workerCount - 1 - w);
        end
        return value;
    endfunction

    task automatic scorePass();
        int value;
        int total;
        logic [workerCount-1:0] seen;
        value = 0;
        total = 0;
        seen = '0;
        for (int w = workerCount - 1; w >= 0; w--) begin
            value = value * workerCount + int'(passJobs[w]);
            total = total + int'(patterns[tableSel * tableWords
                                          + w * workerCount + int'(passJobs[w])]);
            seen[passJobs[w]] = 1'b1;
        end
        checkValue("distinct jobs", (1 << workerCount) - 1, 32'(seen));
        if (passCount == 0) begin
            checkValue("first permutation", encodeOrder(1'b0), value);
        end else if (value <= prevValue) begin
            abortRun($sformatf("table %0d pass %0d did not move to a larger permutation",
                               tableSel, passCount));
        end
        prevValue = value;
        passCount++;
        if (total < tallyMin) begin
            tallyMin = total;
            tallyCount = 1;
        end else if (total == tallyMin) begin
            tallyCount++;
        end
    endtask

    // a pass shows up as worker 0 followed by worker 1, since the counter only moves while busy.
    always @(negedge clk) begin
        if (rst) begin
            passPos = 0;
            passCount = 0;
            prevValue = -1;
            tallyMin = 1 << 30;
            tallyCount = 0;
            prevWorker = '1;
            prevJob = '0;
        end else begin
            if (passPos == 0) begin
                if (worker == indexWidth'(1) && prevWorker == '0) begin
                    passJobs[0] = prevJob;
                    passJobs[1] = job;
                    passPos = 2;
                end
            end else begin
                checkValue("worker order", passPos, int'(worker));
                passJobs[passPos] = job;
                passPos++;
                if (passPos == workerCount) begin
                    scorePass();
                    passPos = 0;
                end
            end
            prevWorker = worker;
            prevJob = job;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            abortRun($sformatf("timeout, the tables were not finished within %0d cycles",
                               cycleLimit));
        end
    end

    task automatic runTable(input int t);
        int base;
        base = t * tableWords;
        @(posedge clk);
        rst <= 1'b1;
        tableSel <= t;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);  // first cycle out of reset.
        checkValue("done after reset", 0, 32'(done));
        checkValue("minCost after reset", (1 << sumWidth) - 1, 32'(minCost));
        checkValue("matchCount after reset", 0, 32'(matchCount));

        while (done !== 1'b1) begin
            @(negedge clk);
        end
        checkValue("pass count at done", permTotal, passCount);
        checkValue("last permutation", encodeOrder(1'b1), prevValue);
        checkValue("minCost against file", 32'(patterns[base + workerCount * workerCount]),
                   32'(minCost));
        checkValue("matchCount against file",
                   32'(patterns[base + workerCount * workerCount + 1]), 32'(matchCount));
        checkValue("minCost against tally", tallyMin, 32'(minCost));
        checkValue("matchCount against tally", tallyCount, 32'(matchCount));

        // the solver must stay quiet once the search is over.
        repeat (settleCycles) @(negedge clk);
        checkValue("passes after done", permTotal, passCount);
        checkValue("done held", 1, 32'(done));
    endtask

    initial begin
        $readmemh("sim/costPatterns.dat", patterns);
        for (int t = 0; t < tableCount; t++) begin
            runTable(t);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: source/costAccumulator.sv
`timescale 1ns/1ns

module costAccumulator (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           permValid,
    input  logic                           lastPerm,
    input  logic                           stop,
    input  logic [costPkg::costWidth-1:0]  cost,
    input  logic [permPkg::indexWidth-1:0] readJob,
    output logic [permPkg::indexWidth-1:0] readWorker,
    output logic [permPkg::indexWidth-1:0] worker,
    output logic [permPkg::indexWidth-1:0] job,
    output logic                           finish,
    output logic                           sumValid,
    output logic                           wasLast,
    output logic [costPkg::sumWidth-1:0]   sum
);
    import permPkg::*;
    import costPkg::*;

    logic [indexWidth-1:0] count;
    logic                  busy;
    logic                  start;
    logic                  lastRead;

    // the permutation is still valid in the finish cycle, so that cycle must not start.
    assign start    = permValid && !busy && !finish && !stop;
    assign lastRead = busy && (count == indexWidth'(workerCount - 1));

    assign readWorker = count;
    assign worker     = count;
    assign job        = readJob;  // the lookup sees the live permutation entry.

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            count    <= '0;
            finish   <= 1'b0;
            sumValid <= 1'b0;
            wasLast  <= 1'b0;
        end else begin
            finish   <= lastRead;
            sumValid <= lastRead;
            if (start) begin
                busy <= 1'b1;
            end else if (lastRead) begin
                busy <= 1'b0;
            end
            if (busy) begin
                count <= count + 1'b1;  // wraps back to worker 0 after worker 7.
            end
            if (lastRead) begin
                wasLast <= lastPerm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sum <= '0;
        end else if (busy) begin
            sum <= sum + sumWidth'(cost);
        end
    end

    // the stepper must hold the permutation for all eight reads of a pass.
    readsOnValidPerm: assert property (@(posedge clk) disable iff (rst)
        busy |-> permValid);

endmodule

// File: source/costPkg.sv
package costPkg;

    // one worker/job cost from the external table.
    localparam int costWidth = 7;

    // eight costs of at most 127 add up to 1016, which fits in ten bits.
    localparam int sumWidth = 10;

    // no more than 40320 permutations can share the minimum.
    localparam int countWidth = 16;

    // the minimum starts above any reachable total.
    localparam logic [sumWidth-1:0] sumInitial = '1;

endpackage

// File: source/jamSolver.sv
`timescale 1ns/1ns

module jamSolver (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [costPkg::costWidth-1:0]  cost,
    output logic [permPkg::indexWidth-1:0] worker,
    output logic [permPkg::indexWidth-1:0] job,
    output logic [costPkg::sumWidth-1:0]   minCost,
    output logic [costPkg::countWidth-1:0] matchCount,
    output logic                           done
);
    import permPkg::*;
    import costPkg::*;

    logic                  permValid;
    logic                  lastPerm;
    logic [indexWidth-1:0] readWorker;
    logic [indexWidth-1:0] readJob;
    logic                  finish;
    logic                  sumValid;
    logic                  wasLast;
    logic [sumWidth-1:0]   sum;

    permutationStepper stepper0 (
        .clk        (clk),
        .rst        (rst),
        .finish     (finish),
        .readWorker (readWorker),
        .readJob    (readJob),
        .permValid  (permValid),
        .lastPerm   (lastPerm)
    );

    // done doubles as the stop request so no pass starts after the last one.
    costAccumulator accumulator0 (
        .clk        (clk),
        .rst        (rst),
        .permValid  (permValid),
        .lastPerm   (lastPerm),
        .stop       (done),
        .cost       (cost),
        .readJob    (readJob),
        .readWorker (readWorker),
        .worker     (worker),
        .job        (job),
        .finish     (finish),
        .sumValid   (sumValid),
        .wasLast    (wasLast),
        .sum        (sum)
    );

    minCostTracker tracker0 (
        .clk        (clk),
        .rst        (rst),
        .sumValid   (sumValid),
        .wasLast    (wasLast),
        .sum        (sum),
        .minCost    (minCost),
        .matchCount (matchCount),
        .done       (done)
    );

endmodule

// File: source/minCostTracker.sv
`timescale 1ns/1ns

module minCostTracker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sumValid,
    input  logic                          wasLast,
    input  logic [costPkg::sumWidth-1:0]  sum,
    output logic [costPkg::sumWidth-1:0]  minCost,
    output logic [costPkg::countWidth-1:0] matchCount,
    output logic                          done
);
    import permPkg::*;
    import costPkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            minCost    <= sumInitial;
            matchCount <= '0;
            done       <= 1'b0;
        end else if (sumValid) begin
            if (sum < minCost) begin
                minCost    <= sum;
                matchCount <= countWidth'(1);  // a new best restarts the count.
            end else if (sum == minCost) begin
                matchCount <= matchCount + 1'b1;
            end
            if (wasLast) begin
                done <= 1'b1;  // held until the next reset.
            end
        end
    end

    // no more permutations than exist can share the minimum.
    countBound: assert property (@(posedge clk) disable iff (rst)
        matchCount <= countWidth'(permTotal));

    // the result is frozen once the search is over.
    frozenAfterDone: assert property (@(posedge clk) disable iff (rst)
        done |=> $stable(minCost) && $stable(matchCount));

endmodule

// File: source/permPkg.sv
package permPkg;

    // the solver assigns eight workers to eight jobs.
    localparam int workerCount = 8;

    // bits of a worker or a job index.
    localparam int indexWidth = 3;

    // permutations of eight jobs (8 factorial).
    localparam int permTotal = 40320;

    // successor search of the permutation stepper.
    //   findPivot   scans upward from worker 0 for the first descent.
    //   findSwap    scans back for the smallest larger entry below the pivot.
    //   reverseTail reverses the entries below the pivot.
    //   holdOut     presents the permutation until the scoring pass ends.
    typedef enum logic [1:0] {
        findPivot,
        findSwap,
        reverseTail,
        holdOut
    } stepState;

endpackage

// File: source/permutationStepper.sv
`timescale 1ns/1ns

module permutationStepper (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           finish,
    input  logic [permPkg::indexWidth-1:0] readWorker,
    output logic [permPkg::indexWidth-1:0] readJob,
    output logic                           permValid,
    output logic                           lastPerm
);
    import permPkg::*;

    logic [indexWidth-1:0] perm [workerCount];  // entry i holds the job of worker i.
    logic [indexWidth-1:0] pivotIdx;
    logic [indexWidth-1:0] swapIdx;
    logic                  hasDescent;
    stepState              state;

    // worker 7 is the most significant digit of the permutation.
    assign readJob   = perm[readWorker];
    assign permValid = (state == holdOut);
    assign lastPerm  = permValid && !hasDescent;  // a fully ascending table has no successor.

    always_comb begin
        hasDescent = 1'b0;
        for (int i = 1; i < workerCount; i++) begin
            if (perm[i] < perm[i-1]) begin
                hasDescent = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < workerCount; i++) begin
                perm[i] <= indexWidth'(workerCount - 1 - i);  // the smallest permutation.
            end
            pivotIdx <= indexWidth'(1);
            swapIdx  <= '0;
            state    <= holdOut;
        end else begin
            case (state)
                holdOut: begin
                    if (finish) begin
                        pivotIdx <= indexWidth'(1);
                        state    <= findPivot;
                    end
                end

                findPivot: begin
                    if (perm[pivotIdx] < perm[pivotIdx - 1'b1]) begin
                        swapIdx <= pivotIdx - 1'b1;  // the pivot stays in pivotIdx.
                        state   <= findSwap;
                    end else if (pivotIdx == indexWidth'(workerCount - 1)) begin
                        state <= holdOut;  // no descent, so the final permutation is kept.
                    end else begin
                        pivotIdx <= pivotIdx + 1'b1;
                    end
                end

                // entries below the pivot ascend with the index, so the first entry
                // found from the top that has a smaller neighbour below is the target.
                findSwap: begin
                    if (swapIdx == '0 || perm[swapIdx - 1'b1] < perm[pivotIdx]) begin
                        perm[swapIdx]  <= perm[pivotIdx];
                        perm[pivotIdx] <= perm[swapIdx];
                        state          <= reverseTail;
                    end else begin
                        swapIdx <= swapIdx - 1'b1;
                    end
                end

                reverseTail: begin
                    for (int i = 0; i < workerCount - 1; i++) begin
                        if (indexWidth'(i) < pivotIdx) begin
                            perm[i] <= perm[pivotIdx - 1'b1 - indexWidth'(i)];
                        end
                    end
                    state <= holdOut;  // the tail now descends and is the smallest suffix.
                end

                default: begin
                    state <= holdOut;
                end
            endcase
        end
    end

    // the accumulator may only end a pass on a stable permutation.
    finishWhileValid: assert property (@(posedge clk) disable iff (rst)
        finish |-> permValid);

endmodule
